/* Makefile */
# Verilator build and run of the SPI loopback tester

VERILATOR   ?= verilator
TOP         := tb_spi_loop_test
FILELIST    := sim.f
OBJ_DIR     := obj_dir
LOG         := sim.log
BUILD_FLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

# the log decides pass or fail
run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/pattern_pkg.sv */
package pattern_pkg;

	// ##############################
	// test sizing
	// ##############################

	localparam int test_length = 64; // bytes per test
	localparam int index_w = 9;
	localparam int data_w = 8;

	typedef logic [index_w-1:0] index_t;
	typedef logic [data_w-1:0] data_t;

	// ##############################
	// payload and status
	// ##############################

	// one byte on its way through the tester
	typedef struct packed {
		data_t  data;  // sent byte, or received byte on the rx side
		index_t index; // frame number within the test
	} byte_tag_t;

	typedef struct packed {
		logic   done;
		logic   receive_status; // all bytes received and matched
		index_t match_count;
	} test_status_t;

	// byte expected back for a given frame
	function automatic data_t expected_byte(index_t index);
		return index[data_w-1:0];
	endfunction

endpackage

/* common/spi_bus_pkg.sv */
package spi_bus_pkg;

	// ##############################
	// bus timing mode
	// ##############################

	typedef enum logic {
		mode_0 = 1'b0, // idle low, launch on fall, sample on rise
		mode_1 = 1'b1  // idle high, launch one clk later, sample on rise
	} mode_e;

	// ##############################
	// frame counter
	// ##############################

	typedef logic [4:0] frame_cnt_t; // clk cycle within a frame

	localparam frame_cnt_t frame_last_m0 = 5'd17; // 18 clk per frame
	localparam frame_cnt_t frame_last_m1 = 5'd18; // 19 clk per frame

	localparam int edges_per_byte = 16; // spi_clk toggles per frame

	// last counter value of a frame
	function automatic frame_cnt_t frame_last(mode_e mode);
		return (mode == mode_1) ? frame_last_m1 : frame_last_m0;
	endfunction

	// level of spi_clk outside the toggle window
	function automatic logic idle_level(mode_e mode);
		return (mode == mode_1);
	endfunction

	// extra clk of delay before the first data bit
	function automatic logic launch_delay(mode_e mode);
		return (mode == mode_1);
	endfunction

endpackage

/* rtl/pattern_source.sv */
`timescale 1ns/1ns

module pattern_source (
	input  logic clk,
	input  logic rst_n,
	input  logic byte_done,
	output pattern_pkg::byte_tag_t tx_tag,
	output logic active,
	output logic done
);

	pattern_pkg::index_t index;
	pattern_pkg::data_t data_byte;
	pattern_pkg::index_t index_end;

	assign index_end = pattern_pkg::index_t'(pattern_pkg::test_length);

	// ##############################
	// byte sequence
	// ##############################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			index <= '0;
			data_byte <= '0;
		end else if (byte_done && active) begin
			index <= index + 1'b1;
			data_byte <= data_byte + 1'b1; // counts with the index
		end
	end

	assign tx_tag.data = data_byte;
	assign tx_tag.index = index;

	assign active = (index < index_end);
	assign done = (index == index_end); // one clk after the last byte_done

	// ##############################
	// checks
	// ##############################

	// the engine must not finish a frame once the test is over
	property p_done_only_active;
		@(posedge clk) disable iff (!rst_n)
		byte_done |-> active;
	endproperty

	a_done_only_active: assert property (p_done_only_active)
		else $error("byte_done while active is low, index %0d", index);

endmodule

/* rtl/rx_checker.sv */
`timescale 1ns/1ns

module rx_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic rx_en,
	input  logic rx_valid,
	input  pattern_pkg::byte_tag_t rx_tag,
	input  logic done,
	output pattern_pkg::test_status_t status
);

	pattern_pkg::index_t match_count;
	pattern_pkg::index_t index_q;
	pattern_pkg::index_t index_end;
	logic rx_en_q;
	logic all_rx; // cleared by any byte finished without rx_en
	logic hit;

	assign index_end = pattern_pkg::index_t'(pattern_pkg::test_length);
	assign hit = (rx_tag.data == pattern_pkg::expected_byte(rx_tag.index));

	// ##############################
	// compare and count
	// ##############################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			match_count <= '0;
			index_q <= '0;
			rx_en_q <= 1'b0;
			all_rx <= 1'b1;
		end else begin
			index_q <= rx_tag.index;
			rx_en_q <= rx_en;
			if (rx_valid && hit) begin
				match_count <= match_count + 1'b1;
			end
			// index step means a byte just completed
			if ((rx_tag.index != index_q) && !rx_en_q) begin
				all_rx <= 1'b0;
			end
		end
	end

	assign status.done = done;
	assign status.receive_status = done && all_rx && (match_count == index_end);
	assign status.match_count = match_count;

	// ##############################
	// checks
	// ##############################

	property p_count_bound;
		@(posedge clk) disable iff (!rst_n)
		match_count <= index_end;
	endproperty

	a_count_bound: assert property (p_count_bound)
		else $error("match_count %0d above test length", match_count);

endmodule

/* rtl/spi_loop_test.sv */
`timescale 1ns/1ns

module spi_loop_test (
	input  logic clk,
	input  logic rst_n,
	input  logic tx_en,
	input  logic rx_en,
	input  spi_bus_pkg::mode_e mode_select,
	input  logic spi_miso,
	output logic spi_clk,
	output logic spi_mosi,
	output pattern_pkg::test_status_t status
);

	pattern_pkg::byte_tag_t tx_tag;
	pattern_pkg::byte_tag_t rx_tag;
	logic active;
	logic done;
	logic byte_done;
	logic rx_valid;

	pattern_source pattern_source_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.byte_done (byte_done),
		.tx_tag    (tx_tag),
		.active    (active),
		.done      (done)
	);

	spi_engine spi_engine_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.tx_en       (tx_en),
		.rx_en       (rx_en),
		.mode_select (mode_select),
		.active      (active),
		.tx_tag      (tx_tag),
		.spi_miso    (spi_miso),
		.spi_clk     (spi_clk),
		.spi_mosi    (spi_mosi),
		.byte_done   (byte_done),
		.rx_valid    (rx_valid),
		.rx_tag      (rx_tag)
	);

	rx_checker rx_checker_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_en    (rx_en),
		.rx_valid (rx_valid),
		.rx_tag   (rx_tag),
		.done     (done),
		.status   (status)
	);

endmodule

/* sim.f */
common/spi_bus_pkg.sv
common/pattern_pkg.sv
rtl/pattern_source.sv
spi_engine/spi_engine.sv
rtl/rx_checker.sv
rtl/spi_loop_test.sv
sim/spi_slave_model.sv
sim/tb_spi_loop_test.sv

/* sim/spi_slave_model.sv */
`timescale 1ns/1ns

module spi_slave_model (
	input  logic rst_n,
	input  logic spi_clk,
	input  logic spi_mosi,
	input  logic source_own, // counting bytes instead of the echo
	input  logic corrupt_en,
	input  logic [7:0] corrupt_index,
	input  logic log_en,
	output logic spi_miso
);

	logic [2:0] bit_cnt;
	logic [7:0] frame_cnt;
	logic [6:0] shift_in;
	logic src_bit;
	logic [7:0] logged [0:255]; // bytes seen on mosi, in order
	int log_count;

	// ##############################
	// miso
	// ##############################

	// engine samples miso before this model sees the rising edge
	assign src_bit = source_own ? frame_cnt[3'd7 - bit_cnt] : spi_mosi;
	assign spi_miso = src_bit ^ (corrupt_en && (frame_cnt == corrupt_index)); // whole byte inverted

	// ##############################
	// mosi capture
	// ##############################

	always @(posedge spi_clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			frame_cnt <= '0;
			shift_in <= '0;
			log_count <= 0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			shift_in <= {shift_in[5:0], spi_mosi};
			if (bit_cnt == 3'd7) begin
				frame_cnt <= frame_cnt + 8'd1;
				if (log_en && (log_count < 256)) begin
					logged[log_count[7:0]] <= {shift_in, spi_mosi};
					log_count <= log_count + 1;
				end
			end
		end
	end

endmodule

/* sim/tb_spi_loop_test.sv */
`timescale 1ns/1ns

module tb_spi_loop_test;

	logic clk;
	logic rst_n;
	logic tx_en;
	logic rx_en;
	spi_bus_pkg::mode_e mode_select;
	logic spi_miso;
	logic spi_clk;
	logic spi_mosi;
	pattern_pkg::test_status_t status;

	logic source_own;
	logic corrupt_en;
	logic [7:0] corrupt_index;
	logic log_en;
	integer seed;
	integer pick;

	// frame timing monitor
	int toggles;
	int since_start;
	bit in_frame;
	bit seen_start;
	logic last_spi_clk;

	always #50 clk = ~clk;

	spi_loop_test spi_loop_test_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.tx_en       (tx_en),
		.rx_en       (rx_en),
		.mode_select (mode_select),
		.spi_miso    (spi_miso),
		.spi_clk     (spi_clk),
		.spi_mosi    (spi_mosi),
		.status      (status)
	);

	spi_slave_model slave_i (
		.rst_n         (rst_n),
		.spi_clk       (spi_clk),
		.spi_mosi      (spi_mosi),
		.source_own    (source_own),
		.corrupt_en    (corrupt_en),
		.corrupt_index (corrupt_index),
		.log_en        (log_en),
		.spi_miso      (spi_miso)
	);

	// ##############################
	// failure reporting
	// ##############################

	task automatic stop_on_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(string name, int expected, int actual);
		$display("FAILED at %0t ns: %s expected %0d actual %0d",
			$time, name, expected, actual);
		stop_on_failure();
	endtask

	task automatic abort_run(string why);
		$display("ERROR at %0t ns: %s", $time, why);
		stop_on_failure();
	endtask

	// clk cycles from one frame start to the next
	function automatic int frame_spacing(spi_bus_pkg::mode_e mode);
		if (mode == spi_bus_pkg::mode_1) begin
			return int'(spi_bus_pkg::frame_last_m1) + 1;
		end
		return int'(spi_bus_pkg::frame_last_m0) + 1;
	endfunction

	// ##############################
	// bus checks
	// ##############################

	a_mosi_idle: assert property (@(posedge clk) disable iff (!rst_n) !tx_en |-> spi_mosi)
		else report_mismatch("spi_mosi", 1, int'($sampled(spi_mosi)));

	a_reset_idle: assert property (@(posedge clk)
		!rst_n |-> (spi_clk == (mode_select == spi_bus_pkg::mode_1)))
		else report_mismatch("spi_clk", int'($sampled(mode_select) == spi_bus_pkg::mode_1),
			int'($sampled(spi_clk)));

	a_tx_only_count: assert property (@(posedge clk) disable iff (!rst_n)
		(tx_en && !rx_en) |-> (status.match_count == '0))
		else report_mismatch("status.match_count", 0, int'($sampled(status.match_count)));

	a_tx_only_status: assert property (@(posedge clk) disable iff (!rst_n)
		(tx_en && !rx_en) |-> !status.receive_status)
		else report_mismatch("status.receive_status", 0,
			int'($sampled(status.receive_status)));

	// toggles come in one unbroken run per frame
	always @(negedge clk) begin
		if (!rst_n) begin
			toggles = 0;
			since_start = 0;
			in_frame = 0;
			seen_start = 0;
		end else begin
			since_start = since_start + 1;
			if (spi_clk !== last_spi_clk) begin
				if (!in_frame) begin
					if (seen_start) begin
						assert (since_start == frame_spacing(mode_select))
							else report_mismatch("frame start spacing",
								frame_spacing(mode_select), since_start);
					end
					since_start = 0;
					toggles = 0;
					seen_start = 1;
					in_frame = 1;
				end
				toggles = toggles + 1;
			end else if (in_frame) begin
				assert (toggles == spi_bus_pkg::edges_per_byte)
					else report_mismatch("spi_clk toggles per frame",
						spi_bus_pkg::edges_per_byte, toggles);
				in_frame = 0;
			end
		end
		last_spi_clk = spi_clk;
	end

	// ##############################
	// scenarios
	// ##############################

	task automatic start_scenario(spi_bus_pkg::mode_e mode, logic tx, logic rx, logic own,
		logic corrupt, logic log_on);
		@(posedge clk);
		#5;
		rst_n = 1'b0;
		mode_select = mode;
		tx_en = tx;
		rx_en = rx;
		source_own = own;
		corrupt_en = corrupt;
		log_en = log_on;
		repeat (8) @(posedge clk);
		#5;
		rst_n = 1'b1;
	endtask

	task automatic wait_done();
		int cycles;
		int limit;
		cycles = 0;
		limit = pattern_pkg::test_length * (int'(spi_bus_pkg::frame_last_m1) + 1) + 100;
		while (!status.done && (cycles < limit)) begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (!status.done) begin
			abort_run("timed out waiting for done");
		end
	endtask

	task automatic run_scenario(spi_bus_pkg::mode_e mode, logic tx, logic rx, logic own,
		logic corrupt, logic log_on, int exp_count, logic exp_status);
		start_scenario(mode, tx, rx, own, corrupt, log_on);
		wait_done();
		repeat (2) @(negedge clk);
		assert (status.done) else report_mismatch("status.done", 1, int'(status.done));
		assert (spi_clk == (mode == spi_bus_pkg::mode_1))
			else report_mismatch("spi_clk", int'(mode == spi_bus_pkg::mode_1), int'(spi_clk));
		assert (int'(status.match_count) == exp_count)
			else report_mismatch("status.match_count", exp_count, int'(status.match_count));
		assert (status.receive_status == exp_status)
			else report_mismatch("status.receive_status", int'(exp_status),
				int'(status.receive_status));
		if (log_on) begin
			assert (slave_i.log_count == pattern_pkg::test_length)
				else report_mismatch("logged byte count", pattern_pkg::test_length,
					slave_i.log_count);
			for (int i = 0; i < pattern_pkg::test_length; i++) begin
				assert (slave_i.logged[i] == i[7:0]) // sent bytes count up from zero
					else report_mismatch($sformatf("logged byte %0d", i), i,
						int'(slave_i.logged[i]));
			end
		end
	endtask

	initial begin
		seed = 55959;
		clk = 1'b0;
		rst_n = 1'b0;
		tx_en = 1'b0;
		rx_en = 1'b0;
		mode_select = spi_bus_pkg::mode_0;
		source_own = 1'b0;
		corrupt_en = 1'b0;
		corrupt_index = '0;
		log_en = 1'b0;

		run_scenario(spi_bus_pkg::mode_0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 64, 1'b1);
		run_scenario(spi_bus_pkg::mode_1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 64, 1'b1);

		pick = $random(seed);
		corrupt_index = {2'b00, pick[5:0]}; // any byte of the 64
		run_scenario(spi_bus_pkg::mode_1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 63, 1'b0);

		run_scenario(spi_bus_pkg::mode_0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 0, 1'b0); // transmit only
		run_scenario(spi_bus_pkg::mode_0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 64, 1'b1); // receive only

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* spi_engine/spi_engine.sv */
`timescale 1ns/1ns

module spi_engine (
	input  logic clk,
	input  logic rst_n,
	input  logic tx_en,
	input  logic rx_en,
	input  spi_bus_pkg::mode_e mode_select,
	input  logic active,
	input  pattern_pkg::byte_tag_t tx_tag,
	input  logic spi_miso,
	output logic spi_clk,
	output logic spi_mosi,
	output logic byte_done,
	output logic rx_valid,
	output pattern_pkg::byte_tag_t rx_tag
);

	spi_bus_pkg::frame_cnt_t cnt;
	spi_bus_pkg::frame_cnt_t cnt_last;
	spi_bus_pkg::frame_cnt_t cnt_first;
	logic run;
	logic toggle;
	logic rise;
	logic clk_phase; // high while spi_clk is away from idle
	logic clk_idle;
	logic [3:0] slot; // bit slot of the current counter pair
	pattern_pkg::data_t rx_shift;

	assign run = active && (tx_en || rx_en);
	assign cnt_last = spi_bus_pkg::frame_last(mode_select);
	assign cnt_first = cnt_last - spi_bus_pkg::frame_cnt_t'(spi_bus_pkg::edges_per_byte);
	assign clk_idle = spi_bus_pkg::idle_level(mode_select);

	// ##############################
	// frame counter
	// ##############################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!run) begin
			cnt <= '0; // abandon a partial frame
		end else if (cnt == cnt_last) begin
			cnt <= '0; // next frame follows at once
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign byte_done = run && (cnt == cnt_last);

	// ##############################
	// spi_clk
	// ##############################

	// counts 1..16 in mode_0, 2..17 in mode_1
	assign toggle = run && (cnt >= cnt_first) && (cnt < cnt_last);
	assign rise = toggle && !spi_clk;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_phase <= 1'b0;
		end else if (!run) begin
			clk_phase <= 1'b0; // back to idle level
		end else if (toggle) begin
			clk_phase <= ~clk_phase;
		end
	end

	assign spi_clk = clk_phase ^ clk_idle;

	// ##############################
	// mosi, MSB first
	// ##############################

	// mode_1 shifts every slot one clk later
	assign slot = cnt[4:1] - {3'b000, spi_bus_pkg::launch_delay(mode_select)};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			spi_mosi <= 1'b1;
		end else if (tx_en && run && (slot < 4'd8)) begin
			spi_mosi <= tx_tag.data[3'd7 - slot[2:0]];
		end else begin
			spi_mosi <= 1'b1; // idle, receive only or past bit 0
		end
	end

	// ##############################
	// miso
	// ##############################

	always_ff @(posedge clk) begin
		if (rise) begin
			rx_shift <= {rx_shift[6:0], spi_miso};
		end
	end

	// last bit is in by the last count of either mode
	assign rx_valid = byte_done && rx_en;
	assign rx_tag.data = rx_shift;
	assign rx_tag.index = tx_tag.index; // live index, moves one clk after byte_done

	// ##############################
	// checks
	// ##############################

	property p_mode_stable;
		@(posedge clk) disable iff (!rst_n)
		(cnt != '0) |-> $stable(mode_select);
	endproperty

	a_mode_stable: assert property (p_mode_stable)
		else $error("mode_select changed inside a frame at count %0d", cnt);

	property p_clk_idle;
		@(posedge clk) disable iff (!rst_n)
		(cnt == '0) |-> (spi_clk == clk_idle);
	endproperty

	a_clk_idle: assert property (p_clk_idle)
		else $error("spi_clk not idle between frames");

endmodule
